// File: common/pim_soc_pkg.sv
package pim_soc_pkg;

    // Bus widths
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;
    typedef logic [7:0]  byte_t;

    // Address map, decoded on bits 31:24
    localparam addr_t IMEM_BASE     = 32'h1000_0000;
    localparam addr_t DMEM_BASE     = 32'h2000_0000;
    localparam addr_t PIM_BUF_BASE  = 32'h4000_0000;
    localparam addr_t PIM_PORT_BASE = 32'h4100_0000;

    // 4096 words per memory by default
    localparam int IDX_W_DEFAULT = 12;

    typedef enum logic [2:0] {
        region_imem,
        region_dmem,
        region_pim_buf,
        region_pim_port,
        region_none
    } region_e;

    typedef enum logic [1:0] {
        apb_idle,
        apb_wait,
        apb_resp
    } apb_state_e;

endpackage

// File: imem/byte_bank_ram.sv
`timescale 1ns/1ps

module byte_bank_ram import pim_soc_pkg::*; #(
    parameter int IDX_W = IDX_W_DEFAULT
) (
    input  logic             clk_i,
    input  logic             en_i,
    input  logic             we_i,
    input  logic [IDX_W-1:0] idx_i,
    input  byte_t            wdata_i,
    output byte_t            rdata_o
);

    byte_t mem [2**IDX_W];

    // Read returns the old byte when a write hits the same index
    always_ff @(posedge clk_i) begin
        if (en_i) begin
            if (we_i) begin
                mem[idx_i] <= wdata_i;
            end
            rdata_o <= mem[idx_i];
        end
    end

endmodule

// File: imem/imem_banked.sv
`timescale 1ns/1ps

module imem_banked import pim_soc_pkg::*; #(
    parameter int IDX_W = IDX_W_DEFAULT
) (
    input  logic  clk_i,
    input  logic  rv_rst_ni,
    input  logic  en_i,
    input  logic  we_i,
    input  addr_t addr_i,
    input  data_t wdata_i,
    input  strb_t strb_i,
    output data_t rdata_o
);

    logic [1:0]       off;
    logic [1:0]       off_q;
    logic [IDX_W-1:0] base_idx;
    byte_t            bank_rdata [4];

    assign off      = addr_i[1:0];
    assign base_idx = addr_i[IDX_W+1:2];

    // Byte offset kept for the read rotation in the next cycle
    always_ff @(posedge clk_i or negedge rv_rst_ni) begin
        if (!rv_rst_ni) begin
            off_q <= '0;
        end else if (en_i) begin
            off_q <= off;
        end
    end

    for (genvar b = 0; b < 4; b++) begin : g_bank
        logic [1:0]       lane;
        logic [IDX_W-1:0] idx;
        byte_t            wbyte;
        logic             bank_we;

        // Bus lane that lands in this bank
        assign lane = 2'(b) - off;

        // Banks below the offset hold bytes of the next word
        assign idx = (2'(b) < off) ? base_idx + IDX_W'(1) : base_idx;

        assign wbyte   = wdata_i[8*lane +: 8];
        assign bank_we = we_i & strb_i[lane];

        byte_bank_ram #(
            .IDX_W   (IDX_W)
        ) u_bank (
            .clk_i   (clk_i),
            .en_i    (en_i),
            .we_i    (bank_we),
            .idx_i   (idx),
            .wdata_i (wbyte),
            .rdata_o (bank_rdata[b])
        );
    end

    // Rotate banks back into bus order
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            rdata_o[8*k +: 8] = bank_rdata[2'(k) + off_q];
        end
    end

endmodule

// File: logic/word_ram.sv
`timescale 1ns/1ps

module word_ram import pim_soc_pkg::*; #(
    parameter int IDX_W = IDX_W_DEFAULT
) (
    input  logic  clk_i,
    input  logic  en_i,
    input  logic  we_i,
    input  addr_t addr_i,
    input  data_t wdata_i,
    input  strb_t strb_i,
    output data_t rdata_o
);

    data_t            mem [2**IDX_W];
    logic [IDX_W-1:0] idx;

    // Word addressed, byte offset dropped
    assign idx = addr_i[IDX_W+1:2];

    always_ff @(posedge clk_i) begin
        if (en_i) begin
            if (we_i) begin
                for (int k = 0; k < 4; k++) begin
                    if (strb_i[k]) begin
                        mem[idx][8*k +: 8] <= wdata_i[8*k +: 8];
                    end
                end
            end
            rdata_o <= mem[idx];
        end
    end

endmodule

// File: logic/apb_mem_decoder.sv
`timescale 1ns/1ps

module apb_mem_decoder import pim_soc_pkg::*; (
    input  logic  clk_i,
    input  logic  rv_rst_ni,

    input  logic  psel_i,
    input  logic  penable_i,
    input  logic  pwrite_i,
    input  addr_t paddr_i,
    input  data_t pwdata_i,
    input  strb_t pstrb_i,
    output data_t prdata_o,
    output logic  pready_o,
    output logic  pslverr_o,

    output addr_t mem_addr_o,
    output data_t mem_wdata_o,
    output strb_t mem_strb_o,
    output logic  mem_we_o,
    output logic  imem_en_o,
    output logic  dmem_en_o,
    output logic  buf_en_o,
    input  data_t imem_rdata_i,
    input  data_t dmem_rdata_i,
    input  data_t buf_rdata_i,

    output data_t pim_addr_o,
    output data_t pim_wr_o,
    input  data_t pim_rd_i
);

    apb_state_e state_q;
    region_e    region_d;
    region_e    region_q;
    logic       mem_go;
    logic       wr_done;

    always_comb begin
        case (paddr_i[31:24])
            IMEM_BASE[31:24]:     region_d = region_imem;
            DMEM_BASE[31:24]:     region_d = region_dmem;
            PIM_BUF_BASE[31:24]:  region_d = region_pim_buf;
            PIM_PORT_BASE[31:24]: region_d = region_pim_port;
            default:              region_d = region_none;
        endcase
    end

    // Region latched in SETUP, held through the transfer
    always_ff @(posedge clk_i or negedge rv_rst_ni) begin
        if (!rv_rst_ni) begin
            state_q  <= apb_idle;
            region_q <= region_none;
        end else begin
            case (state_q)
                apb_idle: begin
                    if (psel_i && !penable_i) begin
                        state_q  <= apb_wait;
                        region_q <= region_d;
                    end
                end
                apb_wait: begin
                    if (mem_go) begin
                        state_q <= pwrite_i ? apb_idle : apb_resp;
                    end
                end
                default: begin
                    state_q <= apb_idle;
                end
            endcase
        end
    end

    // First ACCESS cycle
    assign mem_go  = (state_q == apb_wait) && psel_i && penable_i;
    assign wr_done = mem_go && pwrite_i;

    assign mem_addr_o  = paddr_i;
    assign mem_wdata_o = pwdata_i;
    assign mem_strb_o  = pstrb_i;
    assign mem_we_o    = wr_done;

    assign imem_en_o = mem_go && (region_q == region_imem);
    assign dmem_en_o = mem_go && (region_q == region_dmem);
    assign buf_en_o  = mem_go && (region_q == region_pim_buf);

    // Writes finish at once, reads one cycle later
    assign pready_o  = wr_done || (state_q == apb_resp);
    assign pslverr_o = pready_o && (region_q == region_none);

    always_comb begin
        prdata_o = '0;
        if (state_q == apb_resp) begin
            case (region_q)
                region_imem:     prdata_o = imem_rdata_i;
                region_dmem:     prdata_o = dmem_rdata_i;
                region_pim_buf:  prdata_o = buf_rdata_i;
                region_pim_port: prdata_o = pim_rd_i;
                default:         prdata_o = '0;
            endcase
        end
    end

    // PIM controller registers
    always_ff @(posedge clk_i or negedge rv_rst_ni) begin
        if (!rv_rst_ni) begin
            pim_addr_o <= '0;
            pim_wr_o   <= '0;
        end else if (wr_done && (region_q == region_pim_port)) begin
            pim_addr_o <= paddr_i;
            pim_wr_o   <= pwdata_i;
        end
    end

endmodule

// File: logic/pim_soc_top.sv
`timescale 1ns/1ps

module pim_soc_top import pim_soc_pkg::*; #(
    parameter int IDX_W = IDX_W_DEFAULT
) (
    input  logic  clk_i,
    input  logic  rv_rst_ni,

    // APB slave
    input  logic  psel_i,
    input  logic  penable_i,
    input  logic  pwrite_i,
    input  addr_t paddr_i,
    input  data_t pwdata_i,
    input  strb_t pstrb_i,
    output data_t prdata_o,
    output logic  pready_o,
    output logic  pslverr_o,

    // PIM controller
    output data_t pim_addr_o,
    output data_t pim_wr_o,
    input  data_t pim_rd_i
);

    addr_t mem_addr;
    data_t mem_wdata;
    strb_t mem_strb;
    logic  mem_we;
    logic  imem_en;
    logic  dmem_en;
    logic  buf_en;
    data_t imem_rdata;
    data_t dmem_rdata;
    data_t buf_rdata;

    imem_banked #(
        .IDX_W     (IDX_W)
    ) imem_0 (
        .clk_i     (clk_i),
        .rv_rst_ni (rv_rst_ni),
        .en_i      (imem_en),
        .we_i      (mem_we),
        .addr_i    (mem_addr),
        .wdata_i   (mem_wdata),
        .strb_i    (mem_strb),
        .rdata_o   (imem_rdata)
    );

    word_ram #(
        .IDX_W   (IDX_W)
    ) dmem_ram (
        .clk_i   (clk_i),
        .en_i    (dmem_en),
        .we_i    (mem_we),
        .addr_i  (mem_addr),
        .wdata_i (mem_wdata),
        .strb_i  (mem_strb),
        .rdata_o (dmem_rdata)
    );

    // Weight and activation buffer
    word_ram #(
        .IDX_W   (IDX_W)
    ) pim_buf_ram (
        .clk_i   (clk_i),
        .en_i    (buf_en),
        .we_i    (mem_we),
        .addr_i  (mem_addr),
        .wdata_i (mem_wdata),
        .strb_i  (mem_strb),
        .rdata_o (buf_rdata)
    );

    apb_mem_decoder decoder_0 (
        .clk_i        (clk_i),
        .rv_rst_ni    (rv_rst_ni),
        .psel_i       (psel_i),
        .penable_i    (penable_i),
        .pwrite_i     (pwrite_i),
        .paddr_i      (paddr_i),
        .pwdata_i     (pwdata_i),
        .pstrb_i      (pstrb_i),
        .prdata_o     (prdata_o),
        .pready_o     (pready_o),
        .pslverr_o    (pslverr_o),
        .mem_addr_o   (mem_addr),
        .mem_wdata_o  (mem_wdata),
        .mem_strb_o   (mem_strb),
        .mem_we_o     (mem_we),
        .imem_en_o    (imem_en),
        .dmem_en_o    (dmem_en),
        .buf_en_o     (buf_en),
        .imem_rdata_i (imem_rdata),
        .dmem_rdata_i (dmem_rdata),
        .buf_rdata_i  (buf_rdata),
        .pim_addr_o   (pim_addr_o),
        .pim_wr_o     (pim_wr_o),
        .pim_rd_i     (pim_rd_i)
    );

endmodule

// File: tb/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Bus words and address-carrying outputs
task automatic check_data(input string name, input data_t exp, input data_t act);
    if (act !== exp) begin
        $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        $display("Checks failed");
        $fatal(1, "Data mismatch on %s", name);
    end
endtask

// Single-bit response flags
task automatic check_flag(input string name, input bit exp, input bit act);
    if (act !== exp) begin
        $display("** Error at %0t ns: %s expected %b, got %b", $time, name, exp, act);
        $display("Checks failed");
        $fatal(1, "Flag mismatch on %s", name);
    end
endtask

`endif

// File: tb/tb_pim_soc.sv
`timescale 1ns/1ps

module tb_pim_soc import pim_soc_pkg::*; ();

    localparam int IDX_W     = IDX_W_DEFAULT;
    localparam int BYTE_W    = IDX_W + 2;
    localparam int DRIVE_DLY = 2;
    // About 75 transfers of at most three cycles, with wide margin
    localparam int MAX_CYCLES = 2000;

    logic  clk_i;
    logic  rv_rst_ni;
    logic  psel_i;
    logic  penable_i;
    logic  pwrite_i;
    addr_t paddr_i;
    data_t pwdata_i;
    strb_t pstrb_i;
    data_t prdata_o;
    logic  pready_o;
    logic  pslverr_o;
    data_t pim_addr_o;
    data_t pim_wr_o;
    data_t pim_rd_i;

    int    seed = 32'h922668d5;
    int    cycles;

    // Byte-level model of each memory region
    byte_t imem_bytes [2**BYTE_W];
    byte_t dmem_bytes [2**BYTE_W];
    byte_t buf_bytes  [2**BYTE_W];

    `include "tb_checks.svh"

    pim_soc_top #(
        .IDX_W      (IDX_W)
    ) dut (
        .clk_i      (clk_i),
        .rv_rst_ni  (rv_rst_ni),
        .psel_i     (psel_i),
        .penable_i  (penable_i),
        .pwrite_i   (pwrite_i),
        .paddr_i    (paddr_i),
        .pwdata_i   (pwdata_i),
        .pstrb_i    (pstrb_i),
        .prdata_o   (prdata_o),
        .pready_o   (pready_o),
        .pslverr_o  (pslverr_o),
        .pim_addr_o (pim_addr_o),
        .pim_wr_o   (pim_wr_o),
        .pim_rd_i   (pim_rd_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk_i);
            cycles++;
        end
        $display("Checks failed");
        $fatal(1, "Timeout after %0d cycles", MAX_CYCLES);
    end

    function automatic data_t rand_word();
        return $random(seed);
    endfunction

    function automatic region_e region_of(input addr_t addr);
        if (addr[31:24] == IMEM_BASE[31:24]) return region_imem;
        if (addr[31:24] == DMEM_BASE[31:24]) return region_dmem;
        if (addr[31:24] == PIM_BUF_BASE[31:24]) return region_pim_buf;
        if (addr[31:24] == PIM_PORT_BASE[31:24]) return region_pim_port;
        return region_none;
    endfunction

    // Instruction memory keeps byte k at A+k, word memories drop A[1:0]
    function automatic logic [BYTE_W-1:0] byte_pos(input addr_t addr, input int k);
        if (region_of(addr) == region_imem) begin
            return addr[BYTE_W-1:0] + BYTE_W'(k);
        end
        return {addr[BYTE_W-1:2], 2'b00} + BYTE_W'(k);
    endfunction

    task automatic model_write(input addr_t addr, input data_t data, input strb_t strb);
        logic [BYTE_W-1:0] pos;
        for (int k = 0; k < 4; k++) begin
            pos = byte_pos(addr, k);
            if (strb[k]) begin
                case (region_of(addr))
                    region_imem:    imem_bytes[pos] = data[8*k +: 8];
                    region_dmem:    dmem_bytes[pos] = data[8*k +: 8];
                    region_pim_buf: buf_bytes[pos]  = data[8*k +: 8];
                    default: ;
                endcase
            end
        end
    endtask

    function automatic data_t model_read(input addr_t addr);
        data_t             data;
        logic [BYTE_W-1:0] pos;
        data = '0;
        for (int k = 0; k < 4; k++) begin
            pos = byte_pos(addr, k);
            case (region_of(addr))
                region_imem:    data[8*k +: 8] = imem_bytes[pos];
                region_dmem:    data[8*k +: 8] = dmem_bytes[pos];
                region_pim_buf: data[8*k +: 8] = buf_bytes[pos];
                default:        data[8*k +: 8] = 8'h00;
            endcase
        end
        return data;
    endfunction

    task automatic wait_ready(output int waits);
        waits = 0;
        @(negedge clk_i);
        while (!pready_o) begin
            waits++;
            @(negedge clk_i);
        end
    endtask

    // SETUP, ACCESS until pready, then back to idle
    task automatic apb_transfer(input logic write, input addr_t addr, input data_t data,
                                input strb_t strb, output data_t rdata, output logic err);
        int waits;
        int expected;
        expected = write ? 0 : 1;
        psel_i = 1'b1;
        penable_i = 1'b0;
        pwrite_i = write;
        paddr_i = addr;
        pwdata_i = data;
        pstrb_i = strb;
        @(posedge clk_i);
        #DRIVE_DLY;
        penable_i = 1'b1;
        wait_ready(waits);
        rdata = prdata_o;
        err = pslverr_o;
        if (waits != expected) begin
            $display("Checks failed");
            $fatal(1, "Transfer at %h took %0d wait states instead of %0d",
                   addr, waits, expected);
        end
        @(posedge clk_i);
        #DRIVE_DLY;
        psel_i = 1'b0;
        penable_i = 1'b0;
    endtask

    task automatic apb_write(input addr_t addr, input data_t data, input strb_t strb,
                             output logic err);
        data_t unused;
        apb_transfer(1'b1, addr, data, strb, unused, err);
    endtask

    task automatic apb_read(input addr_t addr, output data_t data, output logic err);
        apb_transfer(1'b0, addr, '0, '0, data, err);
    endtask

    task automatic write_mem(input addr_t addr, input data_t data, input strb_t strb);
        logic err;
        apb_write(addr, data, strb, err);
        check_flag("pslverr_o", 1'b0, err);
        model_write(addr, data, strb);
    endtask

    task automatic read_and_compare(input addr_t addr);
        data_t data;
        logic  err;
        apb_read(addr, data, err);
        check_flag("pslverr_o", 1'b0, err);
        check_data("prdata_o", model_read(addr), data);
    endtask

    task automatic test_reset();
        check_flag("pready_o", 1'b0, pready_o);
        check_flag("pslverr_o", 1'b0, pslverr_o);
        check_data("prdata_o", '0, prdata_o);
        check_data("pim_addr_o", '0, pim_addr_o);
        check_data("pim_wr_o", '0, pim_wr_o);
    endtask

    task automatic test_imem_aligned();
        for (int i = 0; i < 8; i++) begin
            write_mem(IMEM_BASE + addr_t'(4 * i), rand_word(), 4'hF);
        end
        for (int i = 0; i < 8; i++) begin
            read_and_compare(IMEM_BASE + addr_t'(4 * i));
        end
    endtask

    task automatic test_imem_misaligned();
        addr_t ofs [5] = '{32'h05, 32'h0E, 32'h13, 32'h03, addr_t'(2**BYTE_W - 3)};
        strb_t strb [5] = '{4'hF, 4'hB, 4'h6, 4'hF, 4'hF};
        addr_t addr;
        for (int i = 0; i < 5; i++) begin
            addr = IMEM_BASE + ofs[i];
            write_mem(addr, rand_word(), strb[i]);
            read_and_compare(addr);
            // Next aligned word holds the wrapped bytes
            read_and_compare((addr & ~addr_t'(3)) + 32'h4);
        end
        read_and_compare(IMEM_BASE + 32'h01);
        read_and_compare(IMEM_BASE + 32'h0A);
        read_and_compare(IMEM_BASE);
    endtask

    task automatic test_word_mems();
        addr_t dm;
        addr_t bf;
        dm = DMEM_BASE + 32'hC;
        bf = PIM_BUF_BASE + 32'hC;
        write_mem(dm, rand_word(), 4'hF);
        write_mem(bf, rand_word(), 4'hF);
        write_mem(dm + 32'h2, rand_word(), 4'h5);
        read_and_compare(dm + 32'h1);
        read_and_compare(bf);
        read_and_compare(IMEM_BASE + 32'hC);
        write_mem(bf + 32'h3, rand_word(), 4'h8);
        read_and_compare(bf + 32'h2);
        read_and_compare(dm);
        read_and_compare(IMEM_BASE + 32'hC);
        for (int i = 0; i < 4; i++) begin
            dm = DMEM_BASE + addr_t'(4 * (8 + i));
            bf = PIM_BUF_BASE + addr_t'(4 * (8 + i));
            write_mem(dm, rand_word(), 4'hF);
            write_mem(bf, rand_word(), 4'hF);
            write_mem(dm + addr_t'(i), rand_word(), strb_t'(rand_word()));
            read_and_compare(dm);
            read_and_compare(bf);
        end
    endtask

    task automatic test_pim_port();
        addr_t addr;
        data_t data;
        data_t rd;
        logic  err;
        for (int i = 0; i < 2; i++) begin
            addr = PIM_PORT_BASE + addr_t'(64 * (i + 1));
            data = rand_word();
            apb_write(addr, data, 4'hF, err);
            check_flag("pslverr_o", 1'b0, err);
            // Loaded at the edge closing the pready cycle
            check_data("pim_addr_o", addr, pim_addr_o);
            check_data("pim_wr_o", data, pim_wr_o);
        end
        data = rand_word();
        pim_rd_i = data;
        apb_read(PIM_PORT_BASE + 32'h8, rd, err);
        check_flag("pslverr_o", 1'b0, err);
        check_data("prdata_o", data, rd);
        check_data("pim_addr_o", addr, pim_addr_o);
    endtask

    task automatic test_unmapped();
        data_t rd;
        logic  err;
        apb_write(32'h9000_0000, rand_word(), 4'hF, err);
        check_flag("pslverr_o", 1'b1, err);
        apb_read(32'h9000_0000, rd, err);
        check_flag("pslverr_o", 1'b1, err);
        check_data("prdata_o", '0, rd);
        read_and_compare(DMEM_BASE + 32'hC);
        read_and_compare(IMEM_BASE);
    endtask

    initial begin
        rv_rst_ni = 1'b0;
        psel_i = 1'b0;
        penable_i = 1'b0;
        pwrite_i = 1'b0;
        paddr_i = '0;
        pwdata_i = '0;
        pstrb_i = '0;
        pim_rd_i = '0;
        repeat (5) @(posedge clk_i);
        #DRIVE_DLY;
        rv_rst_ni = 1'b1;
        test_reset();
        test_imem_aligned();
        test_imem_misaligned();
        test_word_mems();
        test_pim_port();
        test_unmapped();
        $display("All checks passed");
        $finish;
    end

endmodule

// File: sim.f
+incdir+tb
common/pim_soc_pkg.sv
imem/byte_bank_ram.sv
imem/imem_banked.sv
logic/word_ram.sv
logic/apb_mem_decoder.sv
logic/pim_soc_top.sv
tb/tb_pim_soc.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing -j 0 --top-module tb_pim_soc -f sim.f -o tb_pim_soc_sim
./obj_dir/tb_pim_soc_sim
